//--- hdl/blit_pkg.sv
// Blitter address control definitions
// Widths, pixel-size codes, and the command and descriptor formats
// used by the pointer walkers and the phrase controller
package blit_pkg;

	// One phrase is the 64-bit unit of every write
	localparam int PHRASE_BITS = 64;
	// Bit offset inside a phrase
	localparam int OFS_W = $clog2(PHRASE_BITS);
	// Pointer coordinates
	localparam int COORD_W = 16;
	// Line width and line count
	localparam int CNT_W = 12;

	// Pixel size code; bits per pixel is 2 to the power of the code
	typedef logic [2:0] psize_t;

	localparam psize_t PSIZE_1  = 3'd0;
	localparam psize_t PSIZE_2  = 3'd1;
	localparam psize_t PSIZE_4  = 3'd2;
	localparam psize_t PSIZE_8  = 3'd3;
	localparam psize_t PSIZE_16 = 3'd4;
	localparam psize_t PSIZE_32 = 3'd5;

	// Blit command
	// Width and height must be nonzero
	typedef struct packed {
		logic [COORD_W-1:0] src_x;
		logic [COORD_W-1:0] src_y;
		logic [COORD_W-1:0] dst_x;
		logic [COORD_W-1:0] dst_y;
		psize_t             psize;
		logic [CNT_W-1:0]   width;
		logic [CNT_W-1:0]   height;
		// Whole phrases per step instead of single pixels
		logic               phrase;
	} blit_cmd_t;

	// Write descriptor, one per step
	typedef struct packed {
		logic [COORD_W-1:0] x;
		logic [COORD_W-1:0] y;
		// First bit written in the phrase
		logic [OFS_W-1:0]   dstart;
		// Bit after the last one written, 0 stands for 64
		logic [OFS_W-1:0]   dend;
		// Rotation that lines source data up with the destination
		logic [OFS_W-1:0]   srcshift;
		// Pixels covered, 0 stands for 64 (full phrase at 1 bit per pixel)
		logic [OFS_W-1:0]   pwidth;
		// Final step of the final line
		logic               last;
	} desc_t;

endpackage

//--- hdl/ptr_if.sv
// Pointer to phrase controller link
// The pointer offers its position; the controller accepts it and says how
// many pixels the pointer moves on
interface ptr_if;
	import blit_pkg::*;

	// Position is valid while a walk runs
	logic               valid;
	logic               ready;
	logic [COORD_W-1:0] x;
	logic [COORD_W-1:0] y;
	// Current step reaches the end of the line
	logic               line_end;
	// Walk is on its final line
	logic               last_line;
	// Pixels to advance on a transfer
	logic [CNT_W-1:0]   adv;

	modport pointer (
		output valid, x, y, line_end, last_line,
		input  ready, adv
	);

	modport consumer (
		input  valid, x, y, line_end, last_line,
		output ready, adv
	);

endinterface

//--- hdl/skid_buf.sv
// Two-entry valid/ready register slice
// in_ready is registered, so it never follows out_ready in the same cycle;
// a spare entry catches the item that arrives as the output stalls
module skid_buf #(
	parameter type payload_t = logic
) (
	input  logic     sys_clk,
	input  logic     rst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     main_valid;
	logic     spare_valid;
	payload_t main_data;
	payload_t spare_data;
	// Main entry can take a new item this cycle
	logic     main_free;

	assign main_free = ~main_valid | out_ready;
	// Accept only while the spare entry is empty
	assign in_ready  = ~spare_valid;
	assign out_valid = main_valid;
	assign out_data  = main_data;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			main_valid  <= 1'b0;
			spare_valid <= 1'b0;
		end else if (main_free) begin
			// Spare drains first to keep order
			main_valid  <= spare_valid | in_valid;
			spare_valid <= 1'b0;
		end else if (in_valid && !spare_valid) begin
			spare_valid <= 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (main_free) begin
			main_data <= spare_valid ? spare_data : in_data;
		end else if (in_valid && !spare_valid) begin
			spare_data <= in_data;
		end
	end

endmodule

//--- hdl/pixel_ptr.sv
// Pixel pointer walker
// Steps x across one line of the rectangle by the amount the controller
// asks for, then wraps x to its base and moves down one line
module pixel_ptr (
	input  logic                         sys_clk,
	input  logic                         rst_n,
	input  logic                         load,
	input  logic [blit_pkg::COORD_W-1:0] base_x,
	input  logic [blit_pkg::COORD_W-1:0] base_y,
	input  logic [blit_pkg::CNT_W-1:0]   width,
	input  logic [blit_pkg::CNT_W-1:0]   height,
	ptr_if.pointer                       ptr,
	output logic                         busy
);
	import blit_pkg::*;

	// Walk in progress
	logic               valid_q;
	// Current position
	logic [COORD_W-1:0] x_q;
	logic [COORD_W-1:0] y_q;
	// Line start, kept for the wrap
	logic [COORD_W-1:0] home_x;
	// Line width, kept for the count reload
	logic [CNT_W-1:0]   line_w;
	// Pixels left on this line
	logic [CNT_W-1:0]   rem_px;
	// Lines left, this one included
	logic [CNT_W-1:0]   rem_ln;
	logic               fire;

	assign fire = ptr.valid & ptr.ready;

	assign ptr.valid = valid_q;
	assign ptr.x     = x_q;
	assign ptr.y     = y_q;
	// Step finishes the line when it covers what is left
	assign ptr.line_end  = (rem_px <= ptr.adv);
	assign ptr.last_line = (rem_ln == CNT_W'(1));

	assign busy = valid_q;

	// Walk state and counters
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			rem_px  <= '0;
			rem_ln  <= '0;
		end else if (load) begin
			// Empty rectangle gives no steps at all
			valid_q <= (width != '0) && (height != '0);
			rem_px  <= width;
			rem_ln  <= height;
		end else if (fire) begin
			if (ptr.line_end) begin
				rem_px <= line_w;
				rem_ln <= rem_ln - 1'b1;
				// Final line done
				if (ptr.last_line) begin
					valid_q <= 1'b0;
				end
			end else begin
				rem_px <= rem_px - ptr.adv;
			end
		end
	end

	// Position registers
	always_ff @(posedge sys_clk) begin
		if (load) begin
			x_q    <= base_x;
			y_q    <= base_y;
			home_x <= base_x;
			line_w <= width;
		end else if (fire) begin
			if (ptr.line_end) begin
				// Back to the left edge, one line down
				x_q <= home_x;
				y_q <= y_q + 1'b1;
			end else begin
				x_q <= x_q + COORD_W'(ptr.adv);
			end
		end
	end

endmodule

//--- hdl/phrase_ctrl.sv
// Phrase controller
// Turns the source and destination positions into one write descriptor
// per step: bit masks, source shift and pixel count
// Also tells both pointers how far to move
module phrase_ctrl (
	input  logic                sys_clk,
	input  logic                rst_n,
	input  blit_pkg::blit_cmd_t cmd,
	ptr_if.consumer             src,
	ptr_if.consumer             dst,
	output logic                desc_valid,
	input  logic                desc_ready,
	output blit_pkg::desc_t     desc
);
	import blit_pkg::*;

	// Log2 of bits per pixel
	logic [2:0]       lg;
	// Bit offsets of each pointer inside its phrase
	logic [OFS_W-1:0] dst_ofs;
	logic [OFS_W-1:0] src_ofs;
	// Pixels already covered on the destination line
	logic [CNT_W-1:0] px_done;
	// Pixels still to go on the destination line
	logic [CNT_W-1:0] line_rem;
	// Pixels that fit between dstart and the phrase end, 1 to 64
	logic [6:0]       room;
	// Pixels covered by this step, 1 to 64
	logic [6:0]       step;
	// Bits covered by this step, up to 64
	logic [7:0]       span;
	logic             fire;

	// Pixel size code to shift amount
	// Codes above 32 bits per pixel are treated as 32
	always_comb begin
		case (cmd.psize)
			PSIZE_1:  lg = 3'd0;
			PSIZE_2:  lg = 3'd1;
			PSIZE_4:  lg = 3'd2;
			PSIZE_8:  lg = 3'd3;
			PSIZE_16: lg = 3'd4;
			PSIZE_32: lg = 3'd5;
			default:  lg = 3'd5;
		endcase
	end

	// Pixel index scaled to bits, wrapped to the phrase
	assign dst_ofs = dst.x[OFS_W-1:0] << lg;
	assign src_ofs = src.x[OFS_W-1:0] << lg;

	// Offset is pixel aligned, so the divide is exact
	assign room = (7'(PHRASE_BITS) - {1'b0, dst_ofs}) >> lg;

	assign line_rem = cmd.width - px_done;

	// Step size
	always_comb begin
		if (!cmd.phrase) begin
			// One pixel per write
			step = 7'd1;
		end else if (line_rem < CNT_W'(room)) begin
			// Line ends inside this phrase
			step = line_rem[6:0];
		end else begin
			// Run to the phrase boundary
			step = room;
		end
	end

	assign span = {1'b0, step} << lg;

	// Both pointers move together, only when the output slice has room
	assign desc_valid = src.valid & dst.valid;
	assign src.ready  = desc_valid & desc_ready;
	assign dst.ready  = desc_valid & desc_ready;
	assign fire       = desc_valid & desc_ready;

	assign src.adv = CNT_W'(step);
	assign dst.adv = CNT_W'(step);

	// Descriptor fields
	assign desc.x      = dst.x;
	assign desc.y      = dst.y;
	assign desc.dstart = dst_ofs;
	// A full phrase wraps to 0
	assign desc.dend   = dst_ofs + span[OFS_W-1:0];
	// Rotate left by this to bring source bits under the destination
	assign desc.srcshift = dst_ofs - src_ofs;
	assign desc.pwidth   = step[OFS_W-1:0];
	assign desc.last     = dst.last_line & dst.line_end;

	// Line progress
	// Back to zero at every line end, so it is clear between commands too
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			px_done <= '0;
		end else if (fire) begin
			if (dst.line_end) begin
				px_done <= '0;
			end else begin
				px_done <= px_done + CNT_W'(step);
			end
		end
	end

endmodule

//--- hdl/blit_addr_top.sv
// Blitter address control top
// Command slice, source and destination walkers, phrase controller and
// descriptor output slice; one command runs at a time
module blit_addr_top (
	input  logic                         sys_clk,
	input  logic                         rst_n,
	input  logic                         cmd_valid,
	output logic                         cmd_ready,
	input  logic [blit_pkg::COORD_W-1:0] cmd_src_x,
	input  logic [blit_pkg::COORD_W-1:0] cmd_src_y,
	input  logic [blit_pkg::COORD_W-1:0] cmd_dst_x,
	input  logic [blit_pkg::COORD_W-1:0] cmd_dst_y,
	input  blit_pkg::psize_t             cmd_psize,
	input  logic [blit_pkg::CNT_W-1:0]   cmd_width,
	input  logic [blit_pkg::CNT_W-1:0]   cmd_height,
	input  logic                         cmd_phrase,
	output logic                         desc_valid,
	input  logic                         desc_ready,
	output logic [blit_pkg::COORD_W-1:0] desc_x,
	output logic [blit_pkg::COORD_W-1:0] desc_y,
	output logic [blit_pkg::OFS_W-1:0]   desc_dstart,
	output logic [blit_pkg::OFS_W-1:0]   desc_dend,
	output logic [blit_pkg::OFS_W-1:0]   desc_srcshift,
	output logic [blit_pkg::OFS_W-1:0]   desc_pwidth,
	output logic                         desc_last,
	output logic                         idle
);
	import blit_pkg::*;

	blit_cmd_t cmd_in;
	blit_cmd_t cmd_q;
	logic      cmd_q_valid;
	logic      cmd_sb_ready;
	// Command leaves the slice on the final step
	logic      cmd_pop;
	logic      ptr_load;
	logic      src_busy;
	logic      dst_busy;
	desc_t     pc_desc;
	logic      pc_desc_valid;
	logic      pc_desc_ready;
	desc_t     desc_q;
	// Command accepted and its last descriptor not yet taken
	logic      busy_q;

	assign cmd_in = '{
		src_x:  cmd_src_x,
		src_y:  cmd_src_y,
		dst_x:  cmd_dst_x,
		dst_y:  cmd_dst_y,
		psize:  cmd_psize,
		width:  cmd_width,
		height: cmd_height,
		phrase: cmd_phrase
	};

	assign cmd_ready = ~busy_q & cmd_sb_ready;
	assign idle      = ~busy_q;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
		end else if (cmd_valid && cmd_ready) begin
			busy_q <= 1'b1;
		end else if (desc_valid && desc_ready && desc_last) begin
			busy_q <= 1'b0;
		end
	end

	// Start both walkers once, as the command reaches the slice output
	assign ptr_load = cmd_q_valid & ~src_busy & ~dst_busy;
	assign cmd_pop  = pc_desc_valid & pc_desc_ready & pc_desc.last;

	skid_buf #(.payload_t(blit_cmd_t)) cmd_slice (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.in_valid  (cmd_valid & ~busy_q),
		.in_ready  (cmd_sb_ready),
		.in_data   (cmd_in),
		.out_valid (cmd_q_valid),
		.out_ready (cmd_pop),
		.out_data  (cmd_q)
	);

	ptr_if src_if ();
	ptr_if dst_if ();

	pixel_ptr src_ptr (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.load    (ptr_load),
		.base_x  (cmd_q.src_x),
		.base_y  (cmd_q.src_y),
		.width   (cmd_q.width),
		.height  (cmd_q.height),
		.ptr     (src_if.pointer),
		.busy    (src_busy)
	);

	pixel_ptr dst_ptr (
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.load    (ptr_load),
		.base_x  (cmd_q.dst_x),
		.base_y  (cmd_q.dst_y),
		.width   (cmd_q.width),
		.height  (cmd_q.height),
		.ptr     (dst_if.pointer),
		.busy    (dst_busy)
	);

	phrase_ctrl phrase_ctrl_inst (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.cmd        (cmd_q),
		.src        (src_if.consumer),
		.dst        (dst_if.consumer),
		.desc_valid (pc_desc_valid),
		.desc_ready (pc_desc_ready),
		.desc       (pc_desc)
	);

	skid_buf #(.payload_t(desc_t)) desc_slice (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.in_valid  (pc_desc_valid),
		.in_ready  (pc_desc_ready),
		.in_data   (pc_desc),
		.out_valid (desc_valid),
		.out_ready (desc_ready),
		.out_data  (desc_q)
	);

	assign desc_x        = desc_q.x;
	assign desc_y        = desc_q.y;
	assign desc_dstart   = desc_q.dstart;
	assign desc_dend     = desc_q.dend;
	assign desc_srcshift = desc_q.srcshift;
	assign desc_pwidth   = desc_q.pwidth;
	assign desc_last     = desc_q.last;

endmodule

//--- tests/tb_blit_checks.svh
// Blitter address control checks
// Concurrent assertions on the descriptor port, the command lockout and the
// reset state, plus the error print for a wrong value
`ifndef TB_BLIT_CHECKS_SVH
`define TB_BLIT_CHECKS_SVH

// Wrong value: time, signal, expected and actual
task automatic report_mismatch(input string sig, input logic [63:0] exp_v,
		input logic [63:0] act_v);
	$display("** Error at time %0t: %s expected 0x%0h, got 0x%0h", $time, sig, exp_v, act_v);
	fail_run();
endtask

// Outputs idle right after reset release
reset_state: assert property (@(posedge sys_clk) $rose(rst_n) |-> cmd_ready && idle && !desc_valid)
	else report_mismatch("{cmd_ready,idle,desc_valid}", 3'b110,
		$sampled({cmd_ready, idle, desc_valid}));

// No descriptor without a model entry
desc_expected: assert property (@(posedge sys_clk) disable iff (!rst_n) desc_valid |-> exp_valid)
	else begin
		$display("Error: descriptor offered at time %0t with none expected", $time);
		fail_run();
	end

// Each accepted descriptor against the head of the model queue
chk_x: assert property (@(posedge sys_clk) disable iff (!rst_n)
	desc_valid && desc_ready |-> desc_x == exp_head.x)
	else report_mismatch("desc_x", $sampled(exp_head.x), $sampled(desc_x));
chk_y: assert property (@(posedge sys_clk) disable iff (!rst_n)
	desc_valid && desc_ready |-> desc_y == exp_head.y)
	else report_mismatch("desc_y", $sampled(exp_head.y), $sampled(desc_y));
chk_dstart: assert property (@(posedge sys_clk) disable iff (!rst_n)
	desc_valid && desc_ready |-> desc_dstart == exp_head.dstart)
	else report_mismatch("desc_dstart", $sampled(exp_head.dstart), $sampled(desc_dstart));
chk_dend: assert property (@(posedge sys_clk) disable iff (!rst_n)
	desc_valid && desc_ready |-> desc_dend == exp_head.dend)
	else report_mismatch("desc_dend", $sampled(exp_head.dend), $sampled(desc_dend));
chk_srcshift: assert property (@(posedge sys_clk) disable iff (!rst_n)
	desc_valid && desc_ready |-> desc_srcshift == exp_head.srcshift)
	else report_mismatch("desc_srcshift", $sampled(exp_head.srcshift), $sampled(desc_srcshift));
chk_pwidth: assert property (@(posedge sys_clk) disable iff (!rst_n)
	desc_valid && desc_ready |-> desc_pwidth == exp_head.pwidth)
	else report_mismatch("desc_pwidth", $sampled(exp_head.pwidth), $sampled(desc_pwidth));
chk_last: assert property (@(posedge sys_clk) disable iff (!rst_n)
	desc_valid && desc_ready |-> desc_last == exp_head.last)
	else report_mismatch("desc_last", $sampled(exp_head.last), $sampled(desc_last));

// A stalled descriptor stays offered and unchanged
stall_valid: assert property (@(posedge sys_clk) disable iff (!rst_n)
	desc_valid && !desc_ready |=> desc_valid)
	else report_mismatch("desc_valid", 1, 0);
stall_data: assert property (@(posedge sys_clk) disable iff (!rst_n)
	desc_valid && !desc_ready |=> desc_bus == held_bus)
	else report_mismatch("desc fields", $sampled(held_bus), $sampled(desc_bus));

// One command at a time
lockout: assert property (@(posedge sys_clk) disable iff (!rst_n) tb_busy |-> !cmd_ready)
	else report_mismatch("cmd_ready", 0, 1);
idle_flag: assert property (@(posedge sys_clk) disable iff (!rst_n) idle == !tb_busy)
	else report_mismatch("idle", $sampled(!tb_busy), $sampled(idle));

`endif

//--- tests/tb_blit_addr.sv
// Blitter address control testbench
// Random pixel and phrase walks, back-to-back commands and random output
// stalls, checked against a queue-based reference model
module tb_blit_addr;
	import blit_pkg::*;

	logic               sys_clk = 1'b0;
	logic               rst_n;
	logic               cmd_valid;
	logic               cmd_ready;
	blit_cmd_t          cmd_drv;
	logic               desc_valid;
	logic               desc_ready;
	logic [COORD_W-1:0] desc_x;
	logic [COORD_W-1:0] desc_y;
	logic [OFS_W-1:0]   desc_dstart;
	logic [OFS_W-1:0]   desc_dend;
	logic [OFS_W-1:0]   desc_srcshift;
	logic [OFS_W-1:0]   desc_pwidth;
	logic               desc_last;
	logic               idle;

	// Reference model state
	desc_t              exp_q[$];
	desc_t              exp_head;
	logic               exp_valid;
	// Command accepted and its last descriptor not yet taken
	logic               tb_busy;
	blit_cmd_t          cmds[$];
	logic               bp_on;
	longint             wd_limit;
	// All descriptor fields as one vector for the stall check
	logic [56:0]        desc_bus;
	logic [56:0]        held_bus;

	assign desc_bus = {desc_x, desc_y, desc_dstart, desc_dend, desc_srcshift, desc_pwidth,
		desc_last};

	blit_addr_top blit_addr_top_inst (
		.sys_clk       (sys_clk),
		.rst_n         (rst_n),
		.cmd_valid     (cmd_valid),
		.cmd_ready     (cmd_ready),
		.cmd_src_x     (cmd_drv.src_x),
		.cmd_src_y     (cmd_drv.src_y),
		.cmd_dst_x     (cmd_drv.dst_x),
		.cmd_dst_y     (cmd_drv.dst_y),
		.cmd_psize     (cmd_drv.psize),
		.cmd_width     (cmd_drv.width),
		.cmd_height    (cmd_drv.height),
		.cmd_phrase    (cmd_drv.phrase),
		.desc_valid    (desc_valid),
		.desc_ready    (desc_ready),
		.desc_x        (desc_x),
		.desc_y        (desc_y),
		.desc_dstart   (desc_dstart),
		.desc_dend     (desc_dend),
		.desc_srcshift (desc_srcshift),
		.desc_pwidth   (desc_pwidth),
		.desc_last     (desc_last),
		.idle          (idle)
	);

	task automatic fail_run();
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	`include "tb_blit_checks.svh"

	always #10 sys_clk = ~sys_clk;

	// Walk one command by the step rules; push the descriptors if asked
	// Returns the step count
	function automatic int model_cmd(input blit_cmd_t c, input bit push);
		int    n;
		int    j;
		int    lg;
		int    rem;
		int    room;
		int    step;
		int    ofs_d;
		int    ofs_s;
		logic [COORD_W-1:0] xd;
		logic [COORD_W-1:0] xs;
		desc_t d;
		n  = 0;
		lg = (c.psize > 5) ? 5 : int'(c.psize);
		for (j = 0; j < int'(c.height); j++) begin
			xd  = c.dst_x;
			xs  = c.src_x;
			rem = int'(c.width);
			while (rem > 0) begin
				// Pixel index times bits per pixel within the phrase
				ofs_d = (int'(xd[5:0]) << lg) & 63;
				ofs_s = (int'(xs[5:0]) << lg) & 63;
				room  = (64 - ofs_d) >> lg;
				step  = !c.phrase ? 1 : ((rem < room) ? rem : room);
				d.x        = xd;
				d.y        = COORD_W'(int'(c.dst_y) + j);
				d.dstart   = OFS_W'(ofs_d);
				d.dend     = OFS_W'((ofs_d + (step << lg)) & 63);
				d.srcshift = OFS_W'((ofs_d - ofs_s) & 63);
				d.pwidth   = OFS_W'(step & 63);
				d.last     = (j == int'(c.height) - 1) && (rem == step);
				if (push) begin
					exp_q.push_back(d);
				end
				xd  = xd + COORD_W'(step);
				xs  = xs + COORD_W'(step);
				rem = rem - step;
				n++;
			end
		end
		return n;
	endfunction

	function automatic blit_cmd_t rand_cmd(input int psize, input bit phrase, input int max_w,
			input int max_h);
		blit_cmd_t c;
		c.src_x  = COORD_W'($urandom);
		c.src_y  = COORD_W'($urandom);
		c.dst_x  = COORD_W'($urandom);
		c.dst_y  = COORD_W'($urandom);
		c.psize  = psize_t'(psize);
		c.width  = CNT_W'(1 + $urandom % max_w);
		c.height = CNT_W'(1 + $urandom % max_h);
		c.phrase = phrase;
		return c;
	endfunction

	// Offer a command and hold it until it is taken
	task automatic send_cmd(input blit_cmd_t c);
		cmd_drv   = c;
		cmd_valid = 1'b1;
		@(posedge sys_clk);
		while (!cmd_ready) begin
			@(posedge sys_clk);
		end
		#2;
		cmd_valid = 1'b0;
	endtask

	// Random output stalls once enabled
	task automatic drive_stalls();
		forever begin
			@(posedge sys_clk);
			#2;
			desc_ready = bp_on ? (($urandom % 3) != 0) : 1'b1;
		end
	endtask

	// Model updates on accepted commands and descriptors
	always @(posedge sys_clk) begin
		if (!rst_n) begin
			tb_busy <= 1'b0;
		end else begin
			if (desc_valid && desc_ready && exp_q.size() != 0) begin
				if (exp_q[0].last) begin
					tb_busy <= 1'b0;
				end
				exp_q.delete(0);
			end
			if (cmd_valid && cmd_ready) begin
				tb_busy <= 1'b1;
				void'(model_cmd(cmd_drv, 1'b1));
			end
		end
		exp_valid <= (exp_q.size() != 0);
		if (exp_q.size() != 0) begin
			exp_head <= exp_q[0];
		end
		held_bus <= desc_bus;
	end

	// Watchdog armed once the run length is known
	initial begin
		wait (wd_limit != 0);
		#(wd_limit);
		$display("Error: run did not finish within %0d time units", wd_limit);
		fail_run();
	end

	initial begin
		int total;
		void'($urandom(72564));
		rst_n      = 1'b0;
		cmd_valid  = 1'b0;
		cmd_drv    = '0;
		desc_ready = 1'b1;
		bp_on      = 1'b0;
		wd_limit   = 0;
		total      = 0;
		// Output stalls run alongside the command stream
		fork
			drive_stalls();
		join_none
		// Pixel mode at every size
		for (int p = 0; p < 6; p++) begin
			cmds.push_back(rand_cmd(p, 1'b0, 9, 4));
		end
		// Phrase mode with random bases and widths
		for (int i = 0; i < 12; i++) begin
			cmds.push_back(rand_cmd($urandom % 6, 1'b1, 150, 3));
		end
		// Mixed modes under stalls
		for (int i = 0; i < 8; i++) begin
			cmds.push_back(rand_cmd($urandom % 6, $urandom % 2, 100, 3));
		end
		foreach (cmds[k]) begin
			total += model_cmd(cmds[k], 1'b0);
		end
		wd_limit = (longint'(total) * 20 + 300) * 20;
		repeat (10) @(posedge sys_clk);
		#2;
		rst_n = 1'b1;
		@(posedge sys_clk);
		#2;
		// Commands go back to back so each next one waits out the lockout
		foreach (cmds[k]) begin
			if (k == 18) begin
				@(negedge sys_clk);
				bp_on = 1'b1;
				@(posedge sys_clk);
				#2;
			end
			send_cmd(cmds[k]);
		end
		while (exp_q.size() != 0 || tb_busy) begin
			@(negedge sys_clk);
		end
		repeat (5) @(negedge sys_clk);
		if (desc_valid) begin
			$display("Error: descriptors left over at the end of the run");
			fail_run();
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

//--- sim.f
+incdir+tests
hdl/blit_pkg.sv
hdl/ptr_if.sv
hdl/skid_buf.sv
hdl/pixel_ptr.sv
hdl/phrase_ctrl.sv
hdl/blit_addr_top.sv
tests/tb_blit_addr.sv

//--- Bender.yml
package:
  name: blit_addr

sources:
  - hdl/blit_pkg.sv
  - hdl/ptr_if.sv
  - hdl/skid_buf.sv
  - hdl/pixel_ptr.sv
  - hdl/phrase_ctrl.sv
  - hdl/blit_addr_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_blit_addr.sv
